// ==== hdl/rv64_pkg.sv ====
package rv64_pkg;

  // data and instruction widths
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] exu_info_t;

  // class codes in exu_info[2:0]
  localparam logic [2:0] EXU_INFO_ALU = 3'b001;
  localparam logic [2:0] EXU_INFO_BJP = 3'b010;
  localparam logic [2:0] EXU_INFO_LS  = 3'b100;

  // alu flags
  localparam int EXU_INFO_ALU_ADD    = 3;
  localparam int EXU_INFO_ALU_SUB    = 4;
  localparam int EXU_INFO_ALU_SLL    = 5;
  localparam int EXU_INFO_ALU_SLT    = 6;
  localparam int EXU_INFO_ALU_SLTU   = 7;
  localparam int EXU_INFO_ALU_XOR    = 8;
  localparam int EXU_INFO_ALU_SRL    = 9;
  localparam int EXU_INFO_ALU_SRA    = 10;
  localparam int EXU_INFO_ALU_OR     = 11;
  localparam int EXU_INFO_ALU_AND    = 12;
  localparam int EXU_INFO_ALU_LUI    = 13;
  localparam int EXU_INFO_ALU_EBREAK = 14;
  localparam int EXU_INFO_ALU_WOP    = 15;

  // branch/jump flags, bits 15:11 stay zero
  localparam int EXU_INFO_BJP_JAL  = 3;
  localparam int EXU_INFO_BJP_JALR = 4;
  localparam int EXU_INFO_BJP_BEQ  = 5;
  localparam int EXU_INFO_BJP_BNE  = 6;
  localparam int EXU_INFO_BJP_BLT  = 7;
  localparam int EXU_INFO_BJP_BGE  = 8;
  localparam int EXU_INFO_BJP_BLTU = 9;
  localparam int EXU_INFO_BJP_BGEU = 10;

  // load/store flags, bits 15:10 stay zero
  localparam int EXU_INFO_LS_LOAD  = 3;
  localparam int EXU_INFO_LS_STORE = 4;
  localparam int EXU_INFO_LS_USIGN = 5;
  localparam int EXU_INFO_LS_BYTE  = 6;
  localparam int EXU_INFO_LS_DB    = 7;
  localparam int EXU_INFO_LS_WORD  = 8;
  localparam int EXU_INFO_LS_DW    = 9;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

  typedef enum logic {
    COMMIT_RUN,
    COMMIT_HALT
  } commit_state_e;

endpackage

// ==== hdl/rv64_idu.sv ====
`timescale 1ns/1ns

module rv64_idu (
  input  rv64_pkg::inst_t     inst_i,
  input  rv64_pkg::xlen_t     pc_i,
  input  rv64_pkg::xlen_t     rs1_data_i,
  input  rv64_pkg::xlen_t     rs2_data_i,
  output logic                rd_wr_en_o,
  output logic                rs1_read_en_o,
  output logic                rs2_read_en_o,
  output rv64_pkg::reg_idx_t  rd_idx_o,
  output rv64_pkg::reg_idx_t  rs1_idx_o,
  output rv64_pkg::reg_idx_t  rs2_idx_o,
  output rv64_pkg::xlen_t     op1_o,
  output rv64_pkg::xlen_t     op2_o,
  output rv64_pkg::xlen_t     op1_jp_o,
  output rv64_pkg::xlen_t     op2_jp_o,
  output rv64_pkg::exu_info_t exu_info_o,
  output logic                illegal_o
);

  wire [6:0] opcode = inst_i[6:0];
  wire [7:0] f3     = 8'b1 << inst_i[14:12];
  wire f7_00        = inst_i[31:25] == 7'h00;
  wire f7_20        = inst_i[31:25] == 7'h20;
  // rv64 shifts take a 6-bit shamt
  wire sh_00        = inst_i[31:26] == 6'h00;
  wire sh_10        = inst_i[31:26] == 6'h10;

  // opcode groups
  wire grp_r   = opcode == 7'b0110011;
  wire grp_i   = opcode == 7'b0010011;
  wire grp_rw  = opcode == 7'b0111011;
  wire grp_iw  = opcode == 7'b0011011;
  wire grp_l   = opcode == 7'b0000011;
  wire grp_s   = opcode == 7'b0100011;
  wire grp_b   = opcode == 7'b1100011;
  wire lui     = opcode == 7'b0110111;
  wire auipc   = opcode == 7'b0010111;
  wire jal     = opcode == 7'b1101111;
  wire jalr    = (opcode == 7'b1100111) & f3[0];
  wire ebreak  = inst_i == 32'h0010_0073;

  wire add  = grp_r & f3[0] & f7_00;
  wire sub  = grp_r & f3[0] & f7_20;
  wire sll  = grp_r & f3[1] & f7_00;
  wire slt  = grp_r & f3[2] & f7_00;
  wire sltu = grp_r & f3[3] & f7_00;
  wire xor_ = grp_r & f3[4] & f7_00;
  wire srl  = grp_r & f3[5] & f7_00;
  wire sra  = grp_r & f3[5] & f7_20;
  wire or_  = grp_r & f3[6] & f7_00;
  wire and_ = grp_r & f3[7] & f7_00;
  wire addw = grp_rw & f3[0] & f7_00;
  wire subw = grp_rw & f3[0] & f7_20;
  wire sllw = grp_rw & f3[1] & f7_00;
  wire srlw = grp_rw & f3[5] & f7_00;
  wire sraw = grp_rw & f3[5] & f7_20;

  wire addi  = grp_i & f3[0];
  wire slli  = grp_i & f3[1] & sh_00;
  wire slti  = grp_i & f3[2];
  wire sltiu = grp_i & f3[3];
  wire xori  = grp_i & f3[4];
  wire srli  = grp_i & f3[5] & sh_00;
  wire srai  = grp_i & f3[5] & sh_10;
  wire ori   = grp_i & f3[6];
  wire andi  = grp_i & f3[7];
  wire addiw = grp_iw & f3[0];
  wire slliw = grp_iw & f3[1] & f7_00;
  wire srliw = grp_iw & f3[5] & f7_00;
  wire sraiw = grp_iw & f3[5] & f7_20;

  // funct3 7 is not a load
  wire load  = grp_l & ~f3[7];
  wire store = grp_s & (f3[0] | f3[1] | f3[2] | f3[3]);
  wire beq   = grp_b & f3[0];
  wire bne   = grp_b & f3[1];
  wire blt   = grp_b & f3[4];
  wire bge   = grp_b & f3[5];
  wire bltu  = grp_b & f3[6];
  wire bgeu  = grp_b & f3[7];
  wire branch = beq | bne | blt | bge | bltu | bgeu;

  wire alu_w  = addw | subw | sllw | srlw | sraw | addiw | slliw | srliw | sraiw;
  wire alu_op = add | sub | sll | slt | sltu | xor_ | srl | sra | or_ | and_ |
                addi | slli | slti | sltiu | xori | srli | srai | ori | andi |
                alu_w | lui | auipc | ebreak;
  wire bjp_op = branch | jal | jalr;
  wire ls_op  = load | store;

  // immediates
  rv64_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign imm = ({64{grp_i | grp_iw | grp_l | jalr}} & imm_i) |
               ({64{grp_s}}                         & imm_s) |
               ({64{grp_b}}                         & imm_b) |
               ({64{jal}}                           & imm_j) |
               ({64{lui | auipc}}                   & imm_u);

  assign rd_idx_o  = inst_i[11:7];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  // x0 is never a write target
  assign rd_wr_en_o    = (rd_idx_o != '0) & ((alu_op & ~ebreak) | jal | jalr | load);
  assign rs1_read_en_o = ~(jal | lui | auipc | ebreak);
  assign rs2_read_en_o = grp_r | grp_rw | grp_s | grp_b;

  // operand select
  wire op1_rs1 = ~(jal | jalr | lui | auipc | ebreak);
  wire op1_pc  = auipc | jal | jalr;
  wire op2_rs2 = grp_r | grp_rw | grp_b;
  wire op2_imm = grp_i | grp_iw | grp_l | grp_s | lui | auipc;
  wire op2_4   = jal | jalr;

  assign op1_o = ({64{op1_rs1}} & rs1_data_i) | ({64{op1_pc}} & pc_i);
  assign op2_o = ({64{op2_rs2}} & rs2_data_i) | ({64{op2_imm}} & imm) |
                 ({64{op2_4}} & 64'd4);
  assign op1_jp_o = ({64{jalr}} & rs1_data_i) | ({64{branch | jal}} & pc_i);
  assign op2_jp_o = {64{bjp_op}} & imm;

  rv64_pkg::exu_info_t alu_info, bjp_info, ls_info;

  always_comb begin
    alu_info = '0;
    alu_info[2:0] = rv64_pkg::EXU_INFO_ALU;
    alu_info[rv64_pkg::EXU_INFO_ALU_ADD]    = add | addi | auipc | addw | addiw;
    alu_info[rv64_pkg::EXU_INFO_ALU_SUB]    = sub | subw;
    alu_info[rv64_pkg::EXU_INFO_ALU_SLL]    = sll | slli | sllw | slliw;
    alu_info[rv64_pkg::EXU_INFO_ALU_SLT]    = slt | slti;
    alu_info[rv64_pkg::EXU_INFO_ALU_SLTU]   = sltu | sltiu;
    alu_info[rv64_pkg::EXU_INFO_ALU_XOR]    = xor_ | xori;
    alu_info[rv64_pkg::EXU_INFO_ALU_SRL]    = srl | srli | srlw | srliw;
    alu_info[rv64_pkg::EXU_INFO_ALU_SRA]    = sra | srai | sraw | sraiw;
    alu_info[rv64_pkg::EXU_INFO_ALU_OR]     = or_ | ori;
    alu_info[rv64_pkg::EXU_INFO_ALU_AND]    = and_ | andi;
    alu_info[rv64_pkg::EXU_INFO_ALU_LUI]    = lui;
    alu_info[rv64_pkg::EXU_INFO_ALU_EBREAK] = ebreak;
    alu_info[rv64_pkg::EXU_INFO_ALU_WOP]    = alu_w;
  end

  always_comb begin
    bjp_info = '0;
    bjp_info[2:0] = rv64_pkg::EXU_INFO_BJP;
    bjp_info[rv64_pkg::EXU_INFO_BJP_JAL]  = jal;
    bjp_info[rv64_pkg::EXU_INFO_BJP_JALR] = jalr;
    bjp_info[rv64_pkg::EXU_INFO_BJP_BEQ]  = beq;
    bjp_info[rv64_pkg::EXU_INFO_BJP_BNE]  = bne;
    bjp_info[rv64_pkg::EXU_INFO_BJP_BLT]  = blt;
    bjp_info[rv64_pkg::EXU_INFO_BJP_BGE]  = bge;
    bjp_info[rv64_pkg::EXU_INFO_BJP_BLTU] = bltu;
    bjp_info[rv64_pkg::EXU_INFO_BJP_BGEU] = bgeu;
  end

  always_comb begin
    ls_info = '0;
    ls_info[2:0] = rv64_pkg::EXU_INFO_LS;
    ls_info[rv64_pkg::EXU_INFO_LS_LOAD]  = load;
    ls_info[rv64_pkg::EXU_INFO_LS_STORE] = store;
    ls_info[rv64_pkg::EXU_INFO_LS_USIGN] = load & (f3[4] | f3[5] | f3[6]);
    ls_info[rv64_pkg::EXU_INFO_LS_BYTE]  = f3[0] | f3[4];
    ls_info[rv64_pkg::EXU_INFO_LS_DB]    = f3[1] | f3[5];
    ls_info[rv64_pkg::EXU_INFO_LS_WORD]  = f3[2] | f3[6];
    ls_info[rv64_pkg::EXU_INFO_LS_DW]    = f3[3];
  end

  assign exu_info_o = ({16{alu_op}} & alu_info) | ({16{bjp_op}} & bjp_info) |
                      ({16{ls_op}} & ls_info);
  assign illegal_o  = ~(alu_op | bjp_op | ls_op);

  // groups are disjoint, so a legal word carries exactly one class
  always_comb begin
    assert final (illegal_o || exu_info_o[2:0] inside {rv64_pkg::EXU_INFO_ALU,
      rv64_pkg::EXU_INFO_BJP, rv64_pkg::EXU_INFO_LS});
  end

endmodule

// ==== hdl/rv64_alu.sv ====
`timescale 1ns/1ns

module rv64_alu (
  input  rv64_pkg::xlen_t     op1_i,
  input  rv64_pkg::xlen_t     op2_i,
  input  rv64_pkg::exu_info_t exu_info_i,
  output rv64_pkg::xlen_t     result_o
);

  logic            is_alu;
  logic            wop;
  logic [5:0]      shamt;
  rv64_pkg::xlen_t srl_src;
  rv64_pkg::xlen_t sra_src;
  rv64_pkg::xlen_t raw;

  assign is_alu = exu_info_i[2:0] == rv64_pkg::EXU_INFO_ALU;
  assign wop    = exu_info_i[rv64_pkg::EXU_INFO_ALU_WOP];

  // word ops shift by 5 bits and see only the low word
  assign shamt   = wop ? {1'b0, op2_i[4:0]} : op2_i[5:0];
  assign srl_src = wop ? {32'b0, op1_i[31:0]} : op1_i;
  assign sra_src = wop ? {{32{op1_i[31]}}, op1_i[31:0]} : op1_i;

  always_comb begin
    raw = '0;
    if (exu_info_i[rv64_pkg::EXU_INFO_ALU_ADD]) begin
      raw = op1_i + op2_i;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_SUB]) begin
      raw = op1_i - op2_i;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_SLL]) begin
      raw = op1_i << shamt;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_SLT]) begin
      raw = {63'b0, $signed(op1_i) < $signed(op2_i)};
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_SLTU]) begin
      raw = {63'b0, op1_i < op2_i};
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_XOR]) begin
      raw = op1_i ^ op2_i;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_SRL]) begin
      raw = srl_src >> shamt;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_SRA]) begin
      raw = $signed(sra_src) >>> shamt;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_OR]) begin
      raw = op1_i | op2_i;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_AND]) begin
      raw = op1_i & op2_i;
    end else if (exu_info_i[rv64_pkg::EXU_INFO_ALU_LUI]) begin
      raw = op2_i;
    end
    // ebreak sets no operation flag and falls through to zero
  end

  always_comb begin
    if (!is_alu) begin
      result_o = '0;
    end else if (wop) begin
      result_o = {{32{raw[31]}}, raw[31:0]};
    end else begin
      result_o = raw;
    end
  end

endmodule

// ==== hdl/rv64_bju.sv ====
`timescale 1ns/1ns

module rv64_bju (
  input  rv64_pkg::xlen_t     op1_i,
  input  rv64_pkg::xlen_t     op2_i,
  input  rv64_pkg::xlen_t     op1_jp_i,
  input  rv64_pkg::xlen_t     op2_jp_i,
  input  rv64_pkg::exu_info_t exu_info_i,
  output logic                redirect_o,
  output rv64_pkg::xlen_t     target_o,
  output rv64_pkg::xlen_t     link_o
);

  logic            is_bjp;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;
  rv64_pkg::xlen_t sum;

  assign is_bjp = exu_info_i[2:0] == rv64_pkg::EXU_INFO_BJP;
  assign eq     = op1_i == op2_i;
  assign lt     = $signed(op1_i) < $signed(op2_i);
  assign ltu    = op1_i < op2_i;

  assign taken = (exu_info_i[rv64_pkg::EXU_INFO_BJP_BEQ]  &  eq)  |
                 (exu_info_i[rv64_pkg::EXU_INFO_BJP_BNE]  & ~eq)  |
                 (exu_info_i[rv64_pkg::EXU_INFO_BJP_BLT]  &  lt)  |
                 (exu_info_i[rv64_pkg::EXU_INFO_BJP_BGE]  & ~lt)  |
                 (exu_info_i[rv64_pkg::EXU_INFO_BJP_BLTU] &  ltu) |
                 (exu_info_i[rv64_pkg::EXU_INFO_BJP_BGEU] & ~ltu) |
                 exu_info_i[rv64_pkg::EXU_INFO_BJP_JAL] |
                 exu_info_i[rv64_pkg::EXU_INFO_BJP_JALR];

  assign redirect_o = is_bjp & taken;

  // jalr drops bit 0 of the computed address
  assign sum      = op1_jp_i + op2_jp_i;
  assign target_o = {sum[63:1], sum[0] & ~exu_info_i[rv64_pkg::EXU_INFO_BJP_JALR]};

  // pc + 4 from the decoder
  assign link_o = op1_i + op2_i;

endmodule

// ==== hdl/rv64_regfile.sv ====
`timescale 1ns/1ns

module rv64_regfile (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  rv64_pkg::reg_idx_t rs1_idx_i,
  input  rv64_pkg::reg_idx_t rs2_idx_i,
  input  logic               wr_en_i,
  input  rv64_pkg::reg_idx_t wr_idx_i,
  input  rv64_pkg::xlen_t    wr_data_i,
  output rv64_pkg::xlen_t    rs1_data_o,
  output rv64_pkg::xlen_t    rs2_data_o
);

  // x1..x31 only
  rv64_pkg::xlen_t regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

  // decoder and commit together must never aim a write at x0
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_i |-> wr_idx_i != '0);

endmodule

// ==== hdl/rv64_commit.sv ====
`timescale 1ns/1ns

module rv64_commit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                inst_valid_i,
  input  rv64_pkg::xlen_t     alu_result_i,
  input  logic                redirect_i,
  input  rv64_pkg::xlen_t     target_i,
  input  rv64_pkg::xlen_t     link_i,
  input  logic                rd_wr_en_i,
  input  rv64_pkg::reg_idx_t  rd_idx_i,
  input  rv64_pkg::exu_info_t exu_info_i,
  input  logic                illegal_i,
  output rv64_pkg::xlen_t     pc_o,
  output logic                wr_en_o,
  output rv64_pkg::reg_idx_t  wr_idx_o,
  output rv64_pkg::xlen_t     wr_data_o,
  output logic                retire_valid_o,
  output logic                retire_rd_wr_en_o,
  output rv64_pkg::reg_idx_t  retire_rd_idx_o,
  output rv64_pkg::xlen_t     retire_rd_data_o,
  output logic                retire_illegal_o,
  output logic                halt_o
);

  rv64_pkg::commit_state_e state_q;
  rv64_pkg::xlen_t         pc_next;
  logic                    accept;
  logic                    is_ebreak;
  logic                    bad;

  assign accept    = inst_valid_i && (state_q == rv64_pkg::COMMIT_RUN);
  assign is_ebreak = (exu_info_i[2:0] == rv64_pkg::EXU_INFO_ALU) &&
                     exu_info_i[rv64_pkg::EXU_INFO_ALU_EBREAK];
  // no data memory, so loads and stores retire as unsupported
  assign bad       = illegal_i || (exu_info_i[2:0] == rv64_pkg::EXU_INFO_LS);
  assign halt_o    = state_q == rv64_pkg::COMMIT_HALT;

  assign wr_en_o   = accept && rd_wr_en_i && !bad && !is_ebreak;
  assign wr_idx_o  = rd_idx_i;
  assign wr_data_o = (exu_info_i[2:0] == rv64_pkg::EXU_INFO_BJP) ? link_i : alu_result_i;

  always_comb begin
    if (is_ebreak) begin
      pc_next = pc_o;
    end else if (redirect_i) begin
      pc_next = target_i;
    end else begin
      pc_next = pc_o + 64'd4;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o              <= rv64_pkg::RESET_PC;
      state_q           <= rv64_pkg::COMMIT_RUN;
      retire_valid_o    <= 1'b0;
      retire_rd_wr_en_o <= 1'b0;
      retire_illegal_o  <= 1'b0;
    end else begin
      retire_valid_o    <= accept;
      retire_rd_wr_en_o <= wr_en_o;
      retire_illegal_o  <= accept && bad;
      if (accept) begin
        pc_o <= pc_next;
        if (is_ebreak) begin
          state_q <= rv64_pkg::COMMIT_HALT;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      retire_rd_idx_o  <= rd_idx_i;
      retire_rd_data_o <= wr_data_o;
    end
  end

  // only the ebreak itself retires once halted
  a_halt_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halt_o && $past(halt_o) |-> !retire_valid_o);

endmodule

// ==== hdl/rv64_core.sv ====
`timescale 1ns/1ns

module rv64_core (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  rv64_pkg::inst_t    inst_i,
  input  logic               inst_valid_i,
  output rv64_pkg::xlen_t    pc_o,
  output logic               retire_valid_o,
  output logic               retire_rd_wr_en_o,
  output rv64_pkg::reg_idx_t retire_rd_idx_o,
  output rv64_pkg::xlen_t    retire_rd_data_o,
  output logic               retire_illegal_o,
  output logic               halt_o
);

  rv64_pkg::reg_idx_t  rs1_idx, rs2_idx, rd_idx, wr_idx;
  rv64_pkg::xlen_t     rs1_data, rs2_data, op1, op2, op1_jp, op2_jp;
  rv64_pkg::xlen_t     alu_result, target, link, wr_data;
  rv64_pkg::exu_info_t exu_info;
  logic                rd_wr_en, illegal, redirect, wr_en;

  rv64_idu i_idu (
    .inst_i        (inst_i),
    .pc_i          (pc_o),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rd_wr_en_o    (rd_wr_en),
    .rs1_read_en_o (),
    .rs2_read_en_o (),
    .rd_idx_o      (rd_idx),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .op1_o         (op1),
    .op2_o         (op2),
    .op1_jp_o      (op1_jp),
    .op2_jp_o      (op2_jp),
    .exu_info_o    (exu_info),
    .illegal_o     (illegal)
  );

  rv64_regfile i_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv64_alu i_alu (
    .op1_i      (op1),
    .op2_i      (op2),
    .exu_info_i (exu_info),
    .result_o   (alu_result)
  );

  rv64_bju i_bju (
    .op1_i      (op1),
    .op2_i      (op2),
    .op1_jp_i   (op1_jp),
    .op2_jp_i   (op2_jp),
    .exu_info_i (exu_info),
    .redirect_o (redirect),
    .target_o   (target),
    .link_o     (link)
  );

  rv64_commit i_commit (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .inst_valid_i      (inst_valid_i),
    .alu_result_i      (alu_result),
    .redirect_i        (redirect),
    .target_i          (target),
    .link_i            (link),
    .rd_wr_en_i        (rd_wr_en),
    .rd_idx_i          (rd_idx),
    .exu_info_i        (exu_info),
    .illegal_i         (illegal),
    .pc_o              (pc_o),
    .wr_en_o           (wr_en),
    .wr_idx_o          (wr_idx),
    .wr_data_o         (wr_data),
    .retire_valid_o    (retire_valid_o),
    .retire_rd_wr_en_o (retire_rd_wr_en_o),
    .retire_rd_idx_o   (retire_rd_idx_o),
    .retire_rd_data_o  (retire_rd_data_o),
    .retire_illegal_o  (retire_illegal_o),
    .halt_o            (halt_o)
  );

endmodule

// ==== tests/tb_rv64_core.sv ====
`timescale 1ns/1ns

module tb_rv64_core;

  localparam int ALU_ROUNDS = 3;
  // two resets, alu rounds of two 11-step loads plus 30 ops, then the branch,
  // x0, unsupported and ebreak tests
  localparam int TEST_CYCLES    = 20 + ALU_ROUNDS * 52 + 42 + 3 + 3 + 4;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  localparam logic [6:0] OPC_OP      = 7'h33;
  localparam logic [6:0] OPC_OPIMM   = 7'h13;
  localparam logic [6:0] OPC_OP32    = 7'h3b;
  localparam logic [6:0] OPC_OPIMM32 = 7'h1b;
  localparam logic [6:0] OPC_LUI     = 7'h37;
  localparam logic [6:0] OPC_AUIPC   = 7'h17;
  localparam logic [6:0] OPC_JALR    = 7'h67;
  localparam logic [6:0] OPC_LOAD    = 7'h03;
  localparam logic [6:0] OPC_STORE   = 7'h23;

  logic               clk_i;
  logic               rst_n_i;
  rv64_pkg::inst_t    inst_i;
  logic               inst_valid_i;
  rv64_pkg::xlen_t    pc_o;
  logic               retire_valid_o;
  logic               retire_rd_wr_en_o;
  rv64_pkg::reg_idx_t retire_rd_idx_o;
  rv64_pkg::xlen_t    retire_rd_data_o;
  logic               retire_illegal_o;
  logic               halt_o;

  // shadow architectural state
  rv64_pkg::xlen_t shadow [0:31];
  rv64_pkg::xlen_t exp_pc;
  logic [15:0]     lfsr;
  string           test_name;
  int              test_err;
  int              pass_cnt = 0;
  int              fail_cnt = 0;
  int              rd_cnt = 0;
  int              cycles = 0;

  rv64_core i_dut (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .inst_i            (inst_i),
    .inst_valid_i      (inst_valid_i),
    .pc_o              (pc_o),
    .retire_valid_o    (retire_valid_o),
    .retire_rd_wr_en_o (retire_rd_wr_en_o),
    .retire_rd_idx_o   (retire_rd_idx_o),
    .retire_rd_data_o  (retire_rd_data_o),
    .retire_illegal_o  (retire_illegal_o),
    .halt_o            (halt_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic rv64_pkg::xlen_t rand_bits(input int n);
    rv64_pkg::xlen_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic rv64_pkg::xlen_t sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic rv64_pkg::inst_t r_type(input logic [6:0] f7,
      input rv64_pkg::reg_idx_t rs2, input rv64_pkg::reg_idx_t rs1,
      input logic [2:0] f3, input rv64_pkg::reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic rv64_pkg::inst_t i_type(input logic [11:0] imm,
      input rv64_pkg::reg_idx_t rs1, input logic [2:0] f3,
      input rv64_pkg::reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv64_pkg::inst_t b_type(input logic [12:0] off,
      input rv64_pkg::reg_idx_t rs2, input rv64_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic rv64_pkg::inst_t j_type(input logic [20:0] off,
      input rv64_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv64_pkg::xlen_t a,
      input rv64_pkg::xlen_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_xlen(input string what, input rv64_pkg::xlen_t exp,
      input rv64_pkg::xlen_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
      test_err++;
    end
  endtask

  task automatic check_idx(input string what, input rv64_pkg::reg_idx_t exp,
      input rv64_pkg::reg_idx_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp, act);
      test_err++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      test_err++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err = 0;
  endtask

  task automatic finish_test();
    if (test_err == 0) begin
      pass_cnt++;
      $display("test %s ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", test_name, test_err);
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    inst_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    exp_pc = rv64_pkg::RESET_PC;
  endtask

  // one instruction per cycle, retirement checked one cycle later
  task automatic run_inst(input rv64_pkg::inst_t inst, input logic wr,
      input rv64_pkg::reg_idx_t rd, input rv64_pkg::xlen_t data, input logic ill,
      input rv64_pkg::xlen_t next_pc);
    inst_i = inst;
    inst_valid_i = 1'b1;
    @(posedge clk_i);
    #5;
    inst_valid_i = 1'b0;
    check_bit("retire_valid", 1'b1, retire_valid_o);
    check_bit("retire_rd_wr_en", wr, retire_rd_wr_en_o);
    check_bit("retire_illegal", ill, retire_illegal_o);
    if (wr) begin
      check_idx("retire_rd_idx", rd, retire_rd_idx_o);
      check_xlen("retire_rd_data", data, retire_rd_data_o);
      shadow[rd] = data;
    end
    check_xlen("pc", next_pc, pc_o);
    exp_pc = next_pc;
  endtask

  // top 9 bits, then five 11-bit chunks
  task automatic load_reg(input rv64_pkg::reg_idx_t rd, input rv64_pkg::xlen_t v);
    rv64_pkg::xlen_t acc;
    acc = {55'b0, v[63:55]};
    run_inst(i_type({3'b0, v[63:55]}, 5'd0, 3'd0, rd, OPC_OPIMM), 1'b1, rd, acc, 1'b0,
             exp_pc + 64'd4);
    for (int c = 4; c >= 0; c--) begin
      acc = acc << 11;
      run_inst(i_type(12'd11, rd, 3'd1, rd, OPC_OPIMM), 1'b1, rd, acc, 1'b0, exp_pc + 64'd4);
      acc = acc + v[c*11 +: 11];
      run_inst(i_type({1'b0, v[c*11 +: 11]}, rd, 3'd0, rd, OPC_OPIMM), 1'b1, rd, acc, 1'b0,
               exp_pc + 64'd4);
    end
  endtask

  task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] opc,
      input rv64_pkg::xlen_t exp);
    rv64_pkg::reg_idx_t rd;
    rd = 5'(3 + rd_cnt % 29);
    rd_cnt++;
    run_inst(r_type(f7, 5'd2, 5'd1, f3, rd, opc), 1'b1, rd, exp, 1'b0, exp_pc + 64'd4);
  endtask

  task automatic imm_op(input logic [11:0] imm, input logic [2:0] f3, input logic [6:0] opc,
      input rv64_pkg::xlen_t exp);
    rv64_pkg::reg_idx_t rd;
    rd = 5'(3 + rd_cnt % 29);
    rd_cnt++;
    run_inst(i_type(imm, 5'd1, f3, rd, opc), 1'b1, rd, exp, 1'b0, exp_pc + 64'd4);
  endtask

  task automatic reset_values(input string name);
    start_test(name);
    check_xlen("pc", rv64_pkg::RESET_PC, pc_o);
    check_bit("retire_valid", 1'b0, retire_valid_o);
    check_bit("retire_illegal", 1'b0, retire_illegal_o);
    check_bit("retire_rd_wr_en", 1'b0, retire_rd_wr_en_o);
    check_bit("halt", 1'b0, halt_o);
    finish_test();
  endtask

  task automatic alu_ops();
    rv64_pkg::xlen_t    a;
    rv64_pkg::xlen_t    b;
    rv64_pkg::xlen_t    imm;
    rv64_pkg::xlen_t    uimm;
    logic [11:0]        i12;
    logic [19:0]        u20;
    logic [5:0]         sh;
    logic signed [31:0] aw;
    start_test("alu");
    for (int r = 0; r < ALU_ROUNDS; r++) begin
      a = rand_bits(64);
      b = rand_bits(64);
      i12 = 12'(rand_bits(12));
      u20 = 20'(rand_bits(20));
      sh = 6'(rand_bits(6));
      imm = {{52{i12[11]}}, i12};
      uimm = {{32{u20[19]}}, u20, 12'b0};
      aw = a[31:0];
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      reg_op(7'h00, 3'd0, OPC_OP, a + b);
      reg_op(7'h20, 3'd0, OPC_OP, a - b);
      reg_op(7'h00, 3'd1, OPC_OP, a << b[5:0]);
      reg_op(7'h00, 3'd2, OPC_OP, {63'b0, $signed(a) < $signed(b)});
      reg_op(7'h00, 3'd3, OPC_OP, {63'b0, a < b});
      reg_op(7'h00, 3'd4, OPC_OP, a ^ b);
      reg_op(7'h00, 3'd5, OPC_OP, a >> b[5:0]);
      reg_op(7'h20, 3'd5, OPC_OP, $signed(a) >>> b[5:0]);
      reg_op(7'h00, 3'd6, OPC_OP, a | b);
      reg_op(7'h00, 3'd7, OPC_OP, a & b);
      reg_op(7'h00, 3'd0, OPC_OP32, sext32(a[31:0] + b[31:0]));
      reg_op(7'h20, 3'd0, OPC_OP32, sext32(a[31:0] - b[31:0]));
      reg_op(7'h00, 3'd1, OPC_OP32, sext32(a[31:0] << b[4:0]));
      reg_op(7'h00, 3'd5, OPC_OP32, sext32(a[31:0] >> b[4:0]));
      reg_op(7'h20, 3'd5, OPC_OP32, sext32(aw >>> b[4:0]));
      imm_op(i12, 3'd0, OPC_OPIMM, a + imm);
      imm_op(i12, 3'd2, OPC_OPIMM, {63'b0, $signed(a) < $signed(imm)});
      imm_op(i12, 3'd3, OPC_OPIMM, {63'b0, a < imm});
      imm_op(i12, 3'd4, OPC_OPIMM, a ^ imm);
      imm_op(i12, 3'd6, OPC_OPIMM, a | imm);
      imm_op(i12, 3'd7, OPC_OPIMM, a & imm);
      imm_op({6'h00, sh}, 3'd1, OPC_OPIMM, a << sh);
      imm_op({6'h00, sh}, 3'd5, OPC_OPIMM, a >> sh);
      imm_op({6'h10, sh}, 3'd5, OPC_OPIMM, $signed(a) >>> sh);
      imm_op(i12, 3'd0, OPC_OPIMM32, sext32(a[31:0] + imm[31:0]));
      imm_op({7'h00, sh[4:0]}, 3'd1, OPC_OPIMM32, sext32(a[31:0] << sh[4:0]));
      imm_op({7'h00, sh[4:0]}, 3'd5, OPC_OPIMM32, sext32(a[31:0] >> sh[4:0]));
      imm_op({7'h20, sh[4:0]}, 3'd5, OPC_OPIMM32, sext32(aw >>> sh[4:0]));
      run_inst({u20, 5'd30, OPC_LUI}, 1'b1, 5'd30, uimm, 1'b0, exp_pc + 64'd4);
      run_inst({u20, 5'd31, OPC_AUIPC}, 1'b1, 5'd31, exp_pc + uimm, 1'b0, exp_pc + 64'd4);
    end
    finish_test();
  endtask

  task automatic branch_jump();
    rv64_pkg::xlen_t    a;
    rv64_pkg::xlen_t    b;
    rv64_pkg::xlen_t    tgt;
    rv64_pkg::reg_idx_t rs1;
    rv64_pkg::reg_idx_t rs2;
    logic [12:0]        off;
    logic [20:0]        joff;
    logic [11:0]        i12;
    logic               taken;
    start_test("branch_jump");
    // signed and unsigned order disagree for this pair
    a = rand_bits(64) | 64'h8000_0000_0000_0000;
    b = rand_bits(64) & 64'h7fff_ffff_ffff_ffff;
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    // x1 against x2, x2 against x1, then x1 against itself
    for (int p = 0; p < 3; p++) begin
      rs1 = (p == 1) ? 5'd2 : 5'd1;
      rs2 = (p == 0) ? 5'd2 : 5'd1;
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          off = {12'(rand_bits(12)), 1'b0};
          tgt = exp_pc + {{51{off[12]}}, off};
          taken = branch_taken(3'(f), shadow[rs1], shadow[rs2]);
          run_inst(b_type(off, rs2, rs1, 3'(f)), 1'b0, 5'd0, '0, 1'b0,
                   taken ? tgt : exp_pc + 64'd4);
        end
      end
    end
    joff = {20'(rand_bits(20)), 1'b0};
    tgt = exp_pc + {{43{joff[20]}}, joff};
    run_inst(j_type(joff, 5'd5), 1'b1, 5'd5, exp_pc + 64'd4, 1'b0, tgt);
    // odd sum so that the cleared bit 0 shows
    i12 = 12'(rand_bits(12));
    i12[0] = ~a[0];
    tgt = (a + {{52{i12[11]}}, i12}) & ~64'd1;
    run_inst(i_type(i12, 5'd1, 3'd0, 5'd6, OPC_JALR), 1'b1, 5'd6, exp_pc + 64'd4, 1'b0, tgt);
    finish_test();
  endtask

  task automatic x0_writes();
    start_test("x0");
    run_inst(i_type(12'h123, 5'd1, 3'd0, 5'd0, OPC_OPIMM), 1'b0, 5'd0, '0, 1'b0,
             exp_pc + 64'd4);
    run_inst(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd7, OPC_OP), 1'b1, 5'd7, '0, 1'b0,
             exp_pc + 64'd4);
    run_inst(j_type(21'd8, 5'd0), 1'b0, 5'd0, '0, 1'b0, exp_pc + 64'd8);
    finish_test();
  endtask

  task automatic unsupported_ops();
    start_test("unsupported");
    run_inst(i_type(12'h010, 5'd1, 3'd3, 5'd8, OPC_LOAD), 1'b0, 5'd0, '0, 1'b1,
             exp_pc + 64'd4);
    run_inst(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd8, OPC_STORE), 1'b0, 5'd0, '0, 1'b1,
             exp_pc + 64'd4);
    run_inst(32'h0000_047f, 1'b0, 5'd0, '0, 1'b1, exp_pc + 64'd4);
    finish_test();
  endtask

  task automatic ebreak_halt();
    start_test("ebreak");
    run_inst(32'h0010_0073, 1'b0, 5'd0, '0, 1'b0, exp_pc);
    check_bit("halt", 1'b1, halt_o);
    // valid instructions are ignored while halted
    for (int k = 0; k < 3; k++) begin
      inst_i = i_type(12'd1, 5'd0, 3'd0, 5'd10, OPC_OPIMM);
      inst_valid_i = 1'b1;
      @(posedge clk_i);
      #5;
      check_bit("retire_valid", 1'b0, retire_valid_o);
      check_bit("halt", 1'b1, halt_o);
      check_xlen("pc", exp_pc, pc_o);
    end
    inst_valid_i = 1'b0;
    finish_test();
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    inst_i = '0;
    inst_valid_i = 1'b0;
    lfsr = 16'd50;
    apply_reset();
    reset_values("reset");
    alu_ops();
    branch_jump();
    x0_writes();
    unsupported_ops();
    ebreak_halt();
    apply_reset();
    reset_values("reset_after_halt");
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/rv64_pkg.sv
hdl/rv64_idu.sv
hdl/rv64_alu.sv
hdl/rv64_bju.sv
hdl/rv64_regfile.sv
hdl/rv64_commit.sv
hdl/rv64_core.sv
tests/tb_rv64_core.sv

// ==== Bender.yml ====
package:
  name: rv64_core

sources:
  - files:
      - hdl/rv64_pkg.sv
      - hdl/rv64_idu.sv
      - hdl/rv64_alu.sv
      - hdl/rv64_bju.sv
      - hdl/rv64_regfile.sv
      - hdl/rv64_commit.sv
      - hdl/rv64_core.sv
  - target: test
    files:
      - tests/tb_rv64_core.sv
